//--- logic/caster_pkg.sv
`default_nettype none

package caster_pkg;

    ////////////////////////////////////////
    // Panel geometry, lines and beats
    localparam int V_FP    = 3;
    localparam int V_SYNC  = 1;
    localparam int V_BP    = 2;
    localparam int V_ACT   = 8;
    localparam int V_TOTAL = V_FP + V_SYNC + V_BP + V_ACT;

    localparam int H_FP    = 1;
    localparam int H_SYNC  = 1;
    localparam int H_BP    = 2;
    localparam int H_ACT   = 8;
    localparam int H_TOTAL = H_FP + H_SYNC + H_BP + H_ACT;

    // Wait after frame sync before the scan starts
    localparam int VS_DELAY       = 8;
    localparam int PIPELINE_DELAY = 2;
    localparam int CNT_W          = 11;

    // Four pixels per beat
    localparam int LANES    = 4;
    localparam int PIX_IN_W = 4;
    localparam int STATE_W  = 16;

    localparam int         INIT_FRAMES  = 340;
    localparam logic [5:0] FASTM_FRAMES = 6'd10;

    ////////////////////////////////////////
    // Drive codes and phases
    typedef logic [1:0] drive_t;

    localparam drive_t DRIVE_NOP   = 2'b00;
    localparam drive_t DRIVE_BLACK = 2'b01;
    localparam drive_t DRIVE_WHITE = 2'b10;

    typedef enum logic {
        OP_INIT   = 1'b0,
        OP_NORMAL = 1'b1
    } op_t;

    localparam logic [1:0] MODE_NORMAL_LUT = 2'b00;
    localparam logic [1:0] MODE_FAST_MONO  = 2'b01;
    localparam logic [1:0] MODE_FAST_GREY  = 2'b10;
    localparam logic [1:0] MODE_RESERVED   = 2'b11;

    // Per-pixel state word kept in the framebuffer
    typedef struct packed {
        logic [1:0] mode;
        logic [3:0] reserved;
        logic [5:0] count;
        logic [3:0] prev;
    } pix_state_t;

    // Fast mono, count 0, settled white
    localparam pix_state_t INIT_STATE = 16'h4001;

    ////////////////////////////////////////
    // Init flashing, frame index below a bound takes its code
    localparam int INIT_STEPS = 16;

    localparam int INIT_BOUND [INIT_STEPS] = '{
        48, 50, 108, 110, 178, 180, 258, 260,
        278, 280, 298, 300, 318, 320, 338, INIT_FRAMES
    };

    localparam drive_t INIT_CODE [INIT_STEPS] = '{
        DRIVE_BLACK, DRIVE_NOP, DRIVE_WHITE, DRIVE_NOP,
        DRIVE_BLACK, DRIVE_NOP, DRIVE_WHITE, DRIVE_NOP,
        DRIVE_BLACK, DRIVE_NOP, DRIVE_WHITE, DRIVE_NOP,
        DRIVE_BLACK, DRIVE_NOP, DRIVE_WHITE, DRIVE_NOP
    };

endpackage

`default_nettype wire

//--- logic/scan_if.sv
`default_nettype none

// Scan position flags, one producer and several consumers
interface scan_if;

    logic running;
    logic waiting;
    logic frame_end;

    logic in_vfp;
    logic in_vsync;
    logic in_vbp;
    logic in_vact;

    logic in_hfp;
    logic in_hsync;
    logic in_hbp;
    logic in_hact;

    // Active window moved ahead by the pixel pipeline depth
    logic proc_act;

    modport src (
        output running, waiting, frame_end,
        output in_vfp, in_vsync, in_vbp, in_vact,
        output in_hfp, in_hsync, in_hbp, in_hact,
        output proc_act
    );

    modport seq (input frame_end);

    modport pipe (input proc_act);

    modport pins (
        input waiting,
        input in_vsync, in_vbp, in_vact,
        input in_hfp, in_hsync, in_hbp, in_hact
    );

endinterface

`default_nettype wire

//--- logic/scan_timing.sv
`default_nettype none

module scan_timing (
    input  wire  clk,
    input  wire  rst,
    input  wire  sys_ready,
    input  wire  vin_vsync,
    scan_if.src  scan
);

    typedef logic [caster_pkg::CNT_W-1:0] cnt_t;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT,
        S_RUN
    } scan_state_t;

    scan_state_t state;
    cnt_t        h_cnt;
    cnt_t        v_cnt;

    logic run;
    logic h_last;
    logic v_last;

    ////////////////////////////////////////
    // Frame FSM and counters
    assign run    = (state == S_RUN);
    assign h_last = (h_cnt == cnt_t'(caster_pkg::H_TOTAL - 1));
    assign v_last = (v_cnt == cnt_t'(caster_pkg::V_TOTAL - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    h_cnt <= '0;
                    v_cnt <= '0;
                    if (sys_ready && vin_vsync) begin
                        state <= S_WAIT;
                    end
                end
                // h_cnt times the sync delay here
                S_WAIT: begin
                    if (h_cnt == cnt_t'(caster_pkg::VS_DELAY)) begin
                        state <= S_RUN;
                        h_cnt <= '0;
                    end else begin
                        h_cnt <= h_cnt + 1'b1;
                    end
                end
                S_RUN: begin
                    if (h_last) begin
                        h_cnt <= '0;
                        if (v_last) begin
                            state <= S_IDLE;
                            v_cnt <= '0;
                        end else begin
                            v_cnt <= v_cnt + 1'b1;
                        end
                    end else begin
                        h_cnt <= h_cnt + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // Region decodes, all quiet unless running
    assign scan.running   = run;
    assign scan.waiting   = (state == S_WAIT);
    assign scan.frame_end = run && h_last && v_last;

    assign scan.in_vfp   = run && (v_cnt < cnt_t'(caster_pkg::V_FP));
    assign scan.in_vsync = run && (v_cnt >= cnt_t'(caster_pkg::V_FP))
                           && (v_cnt < cnt_t'(caster_pkg::V_FP + caster_pkg::V_SYNC));
    assign scan.in_vbp   = run
                           && (v_cnt >= cnt_t'(caster_pkg::V_FP + caster_pkg::V_SYNC))
                           && (v_cnt < cnt_t'(caster_pkg::V_TOTAL - caster_pkg::V_ACT));
    assign scan.in_vact  = run && (v_cnt >= cnt_t'(caster_pkg::V_TOTAL - caster_pkg::V_ACT));

    assign scan.in_hfp   = run && (h_cnt < cnt_t'(caster_pkg::H_FP));
    assign scan.in_hsync = run && (h_cnt >= cnt_t'(caster_pkg::H_FP))
                           && (h_cnt < cnt_t'(caster_pkg::H_FP + caster_pkg::H_SYNC));
    assign scan.in_hbp   = run
                           && (h_cnt >= cnt_t'(caster_pkg::H_FP + caster_pkg::H_SYNC))
                           && (h_cnt < cnt_t'(caster_pkg::H_TOTAL - caster_pkg::H_ACT));
    assign scan.in_hact  = run && (h_cnt >= cnt_t'(caster_pkg::H_TOTAL - caster_pkg::H_ACT));

    // Same width as hact, PIPELINE_DELAY beats early
    assign scan.proc_act = run && scan.in_vact
        && (h_cnt >= cnt_t'(caster_pkg::H_TOTAL - caster_pkg::H_ACT - caster_pkg::PIPELINE_DELAY))
        && (h_cnt < cnt_t'(caster_pkg::H_TOTAL - caster_pkg::PIPELINE_DELAY));

endmodule

`default_nettype wire

//--- logic/op_sequencer.sv
`default_nettype none

module op_sequencer (
    input  wire                 clk,
    input  wire                 rst,
    scan_if.seq                 scan,
    output caster_pkg::op_t     op,
    output caster_pkg::drive_t  init_drive
);

    logic [caster_pkg::CNT_W-1:0] frame_idx;

    ////////////////////////////////////////
    // Phase tracking
    always_ff @(posedge clk) begin
        if (rst) begin
            op        <= caster_pkg::OP_INIT;
            frame_idx <= '0;
        end else if (scan.frame_end && (op == caster_pkg::OP_INIT)) begin
            if (frame_idx == caster_pkg::CNT_W'(caster_pkg::INIT_FRAMES - 1)) begin
                op        <= caster_pkg::OP_NORMAL;
                frame_idx <= '0;
            end else begin
                frame_idx <= frame_idx + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Init waveform lookup
    // Walk from the top so the lowest matching bound wins
    always_comb begin
        init_drive = caster_pkg::DRIVE_NOP;
        for (int i = caster_pkg::INIT_STEPS - 1; i >= 0; i--) begin
            if (int'(frame_idx) < caster_pkg::INIT_BOUND[i]) begin
                init_drive = caster_pkg::INIT_CODE[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/pixel_update.sv
`default_nettype none

module pixel_update (
    input  wire [caster_pkg::PIX_IN_W-1:0]  vin,
    input  wire caster_pkg::pix_state_t     state_in,
    input  wire caster_pkg::op_t            op,
    input  wire caster_pkg::drive_t         init_drive,
    output caster_pkg::drive_t              drive,
    output caster_pkg::pix_state_t          state_out
);

    // Mono target from the top input bit, 1 is white
    logic               target;
    caster_pkg::drive_t target_code;

    assign target      = vin[caster_pkg::PIX_IN_W-1];
    assign target_code = target ? caster_pkg::DRIVE_WHITE : caster_pkg::DRIVE_BLACK;

    always_comb begin
        drive     = caster_pkg::DRIVE_NOP;
        state_out = state_in;

        if (op == caster_pkg::OP_INIT) begin
            // Whole screen flashing
            drive     = init_drive;
            state_out = caster_pkg::INIT_STATE;
        end else if (state_in.mode != caster_pkg::MODE_FAST_MONO) begin
            // Unsupported modes
            state_out = '0;
        end else if (state_in.count != 6'd0) begin
            // Mid transition, always follow the input
            drive = target_code;
            if (target == state_in.prev[0]) begin
                state_out.count = state_in.count - 6'd1;
            end else begin
                // Reversal, only the frames already spent need undoing
                state_out.count = caster_pkg::FASTM_FRAMES - state_in.count + 6'd2;
                state_out.prev  = {3'b000, target};
            end
        end else if (target != state_in.prev[0]) begin
            // Settled pixel with a new target
            drive           = target_code;
            state_out.count = caster_pkg::FASTM_FRAMES;
            state_out.prev  = {3'b000, target};
        end
    end

endmodule

`default_nettype wire

//--- logic/pixel_datapath.sv
`default_nettype none

module pixel_datapath (
    input  wire                                            clk,
    input  wire                                            rst,
    scan_if.pipe                                           scan,
    input  wire caster_pkg::op_t                           op,
    input  wire caster_pkg::drive_t                        init_drive,
    input  wire [caster_pkg::LANES*caster_pkg::PIX_IN_W-1:0] vin_pixel,
    input  wire [caster_pkg::LANES*caster_pkg::STATE_W-1:0]  bi_pixel,
    output logic [2*caster_pkg::LANES-1:0]                 epd_sd,
    output logic [caster_pkg::LANES*caster_pkg::STATE_W-1:0] bo_pixel
);

    localparam int DW = 2 * caster_pkg::LANES;
    localparam int SW = caster_pkg::LANES * caster_pkg::STATE_W;

    logic [DW-1:0] lane_drive;
    logic [SW-1:0] lane_state;

    logic          s1_tag;
    logic          s2_tag;
    logic [DW-1:0] s1_drive;
    logic [DW-1:0] s2_drive;
    logic [SW-1:0] s1_state;
    logic [SW-1:0] s2_state;

    for (genvar i = 0; i < caster_pkg::LANES; i++) begin : g_lane
        pixel_update u_update (
            .vin        (vin_pixel[i*caster_pkg::PIX_IN_W +: caster_pkg::PIX_IN_W]),
            .state_in   (bi_pixel[i*caster_pkg::STATE_W +: caster_pkg::STATE_W]),
            .op         (op),
            .init_drive (init_drive),
            .drive      (lane_drive[2*i +: 2]),
            .state_out  (lane_state[i*caster_pkg::STATE_W +: caster_pkg::STATE_W])
        );
    end

    ////////////////////////////////////////
    // Two stage output pipeline
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_tag <= 1'b0;
            s2_tag <= 1'b0;
        end else begin
            s1_tag <= scan.proc_act;
            s2_tag <= s1_tag;
        end
    end

    always_ff @(posedge clk) begin
        s1_drive <= lane_drive;
        s1_state <= lane_state;
        s2_drive <= s1_drive;
        s2_state <= s1_state;
    end

    // Source lines idle outside tagged beats
    assign epd_sd   = s2_tag ? s2_drive : '0;
    assign bo_pixel = s2_state;

endmodule

`default_nettype wire

//--- logic/epd_drive.sv
`default_nettype none

module epd_drive (
    input  wire   clk,
    input  wire   rst,
    scan_if.pins  scan,
    output logic  b_trigger,
    output logic  bo_valid,
    output logic  epd_gdoe,
    output logic  epd_gdclk,
    output logic  epd_gdsp,
    output logic  epd_sdclk,
    output logic  epd_sdle,
    output logic  epd_sdoe,
    output logic  epd_sdce0
);

    logic in_act;
    logic gdclk_pre;

    assign in_act = scan.in_vact && scan.in_hact;

    // Gate driver
    assign epd_gdoe  = scan.in_vsync || scan.in_vbp || scan.in_vact;
    assign epd_gdsp  = !scan.in_vsync;
    assign gdclk_pre = scan.in_hsync || scan.in_hbp || scan.in_hact;

    // Gate clock trails the line by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            epd_gdclk <= 1'b0;
        end else begin
            epd_gdclk <= gdclk_pre;
        end
    end

    // Source driver
    assign epd_sdoe  = epd_gdoe;
    assign epd_sdle  = scan.in_hsync;
    assign epd_sdce0 = !in_act;
    assign epd_sdclk = (scan.in_hfp || scan.in_hsync || scan.in_hact) ? ~clk : 1'b0;

    // Framebuffer side
    assign bo_valid  = in_act;
    assign b_trigger = scan.waiting;

endmodule

`default_nettype wire

//--- logic/caster_top.sv
`default_nettype none

module caster_top (
    input  wire         clk,
    input  wire         rst,
    input  wire         sys_ready,
    // Incoming image, four Y4 pixels per beat
    input  wire         vin_vsync,
    input  wire [15:0]  vin_pixel,
    input  wire         vin_valid,
    output logic        vin_ready,
    // Framebuffer read and write back
    output logic        b_trigger,
    input  wire [63:0]  bi_pixel,
    input  wire         bi_valid,
    output logic        bi_ready,
    output logic [63:0] bo_pixel,
    output logic        bo_valid,
    // Panel pins
    output logic        epd_gdoe,
    output logic        epd_gdclk,
    output logic        epd_gdsp,
    output logic        epd_sdclk,
    output logic        epd_sdle,
    output logic        epd_sdoe,
    output logic [7:0]  epd_sd,
    output logic        epd_sdce0
);

    caster_pkg::op_t    op;
    caster_pkg::drive_t init_drive;

    scan_if scan ();

    scan_timing u_scan_timing (
        .clk       (clk),
        .rst       (rst),
        .sys_ready (sys_ready),
        .vin_vsync (vin_vsync),
        .scan      (scan.src)
    );

    op_sequencer u_op_sequencer (
        .clk        (clk),
        .rst        (rst),
        .scan       (scan.seq),
        .op         (op),
        .init_drive (init_drive)
    );

    pixel_datapath u_pixel_datapath (
        .clk        (clk),
        .rst        (rst),
        .scan       (scan.pipe),
        .op         (op),
        .init_drive (init_drive),
        .vin_pixel  (vin_pixel),
        .bi_pixel   (bi_pixel),
        .epd_sd     (epd_sd),
        .bo_pixel   (bo_pixel)
    );

    epd_drive u_epd_drive (
        .clk       (clk),
        .rst       (rst),
        .scan      (scan.pins),
        .b_trigger (b_trigger),
        .bo_valid  (bo_valid),
        .epd_gdoe  (epd_gdoe),
        .epd_gdclk (epd_gdclk),
        .epd_gdsp  (epd_gdsp),
        .epd_sdclk (epd_sdclk),
        .epd_sdle  (epd_sdle),
        .epd_sdoe  (epd_sdoe),
        .epd_sdce0 (epd_sdce0)
    );

    // Upstream is trusted to keep pace, valid flags are not examined
    assign vin_ready = scan.proc_act;
    assign bi_ready  = scan.proc_act;

endmodule

`default_nettype wire

//--- bench/caster_tb.sv
`default_nettype none

module caster_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ACCEPT_TIMEOUT  = 8;
    localparam int TRIGGER_TIMEOUT = 32;
    localparam int NORMAL_FRAMES   = 4;

    // Idle levels of b_trigger, ready, bo_valid, panel pins and epd_sd
    localparam logic [18:0] CTRL_IDLE = {6'b000000, 1'b1, 2'b00, 1'b1, 1'b0, 8'h00};

    logic        clk = 1'b0;
    logic        rst;
    logic        sys_ready;
    logic        vin_vsync;
    logic [15:0] vin_pixel = '0;
    logic        vin_valid;
    logic [63:0] bi_pixel = '0;
    logic        bi_valid;

    logic        vin_ready;
    logic        b_trigger;
    logic        bi_ready;
    logic [63:0] bo_pixel;
    logic        bo_valid;
    logic        epd_gdoe;
    logic        epd_gdclk;
    logic        epd_gdsp;
    logic        epd_sdclk;
    logic        epd_sdle;
    logic        epd_sdoe;
    logic [7:0]  epd_sd;
    logic        epd_sdce0;

    integer      seed = 32'h33552a52;
    int          frames_done;
    logic        quiet;
    logic        timed_out;
    int          check_errors;
    int          count_errors;
    int          timeout_errors;

    // Expected results, two beats deep
    logic        exp1_valid;
    logic        exp2_valid;
    logic [7:0]  exp1_sd;
    logic [7:0]  exp2_sd;
    logic [63:0] exp1_bo;
    logic [63:0] exp2_bo;

    logic [18:0] ctrl_bus;

    always #2 clk = ~clk;

    caster_top u_caster_top (
        .clk       (clk),
        .rst       (rst),
        .sys_ready (sys_ready),
        .vin_vsync (vin_vsync),
        .vin_pixel (vin_pixel),
        .vin_valid (vin_valid),
        .vin_ready (vin_ready),
        .b_trigger (b_trigger),
        .bi_pixel  (bi_pixel),
        .bi_valid  (bi_valid),
        .bi_ready  (bi_ready),
        .bo_pixel  (bo_pixel),
        .bo_valid  (bo_valid),
        .epd_gdoe  (epd_gdoe),
        .epd_gdclk (epd_gdclk),
        .epd_gdsp  (epd_gdsp),
        .epd_sdclk (epd_sdclk),
        .epd_sdle  (epd_sdle),
        .epd_sdoe  (epd_sdoe),
        .epd_sd    (epd_sd),
        .epd_sdce0 (epd_sdce0)
    );

    assign ctrl_bus = {b_trigger, vin_ready, bi_ready, bo_valid, epd_gdoe, epd_sdoe,
                       epd_gdsp, epd_gdclk, epd_sdle, epd_sdce0, epd_sdclk, epd_sd};

    ////////////////////////////////////////
    // Reference model

    // Init flashing code for a frame index
    function automatic logic [1:0] init_code(int idx);
        if (idx < 48) return 2'b01;
        else if (idx < 50) return 2'b00;
        else if (idx < 108) return 2'b10;
        else if (idx < 110) return 2'b00;
        else if (idx < 178) return 2'b01;
        else if (idx < 180) return 2'b00;
        else if (idx < 258) return 2'b10;
        else if (idx < 260) return 2'b00;
        else if (idx < 278) return 2'b01;
        else if (idx < 280) return 2'b00;
        else if (idx < 298) return 2'b10;
        else if (idx < 300) return 2'b00;
        else if (idx < 318) return 2'b01;
        else if (idx < 320) return 2'b00;
        else if (idx < 338) return 2'b10;
        return 2'b00;
    endfunction

    // Returns {drive, new state} for one pixel
    function automatic logic [17:0] update_pixel(logic [3:0] vin, logic [15:0] st,
                                                 logic init, logic [1:0] init_drv);
        logic        target;
        logic [1:0]  code;
        logic [5:0]  count;
        logic [15:0] nxt;
        target = vin[3];
        code   = target ? 2'b10 : 2'b01;
        count  = st[9:4];
        nxt    = st;
        if (init) return {init_drv, 16'h4001};
        if (st[15:14] != 2'b01) return 18'h0;
        if (count != 6'd0) begin
            if (target == st[0]) begin
                nxt[9:4] = count - 6'd1;
            end else begin
                nxt[9:4] = 6'd10 - count + 6'd2;
                nxt[3:0] = {3'b000, target};
            end
            return {code, nxt};
        end
        if (target == st[0]) return {2'b00, st};
        nxt[9:4] = 6'd10;
        nxt[3:0] = {3'b000, target};
        return {code, nxt};
    endfunction

    always @(posedge clk) begin : ref_model
        logic [17:0] res;
        logic [7:0]  sd;
        logic [63:0] bo;
        logic        init;
        init = (frames_done < caster_pkg::INIT_FRAMES);
        for (int i = 0; i < 4; i++) begin
            res = update_pixel(vin_pixel[4*i +: 4], bi_pixel[16*i +: 16], init,
                               init_code(frames_done));
            sd[2*i +: 2]   = res[17:16];
            bo[16*i +: 16] = res[15:0];
        end
        if (rst) begin
            exp1_valid <= 1'b0;
            exp2_valid <= 1'b0;
        end else begin
            exp1_valid <= vin_ready;
            exp1_sd    <= sd;
            exp1_bo    <= bo;
            exp2_valid <= exp1_valid;
            exp2_sd    <= exp1_sd;
            exp2_bo    <= exp1_bo;
        end
    end

    ////////////////////////////////////////
    // Checks on every edge
    assert property (@(posedge clk) disable iff (rst) bo_valid == exp2_valid)
        else begin
            $display("Fail bo_valid expected 0x%h got 0x%h", $sampled(exp2_valid),
                     $sampled(bo_valid));
            check_errors++;
        end

    assert property (@(posedge clk) disable iff (rst) epd_sdce0 == !bo_valid)
        else begin
            $display("Fail epd_sdce0 expected 0x%h got 0x%h", $sampled(!bo_valid),
                     $sampled(epd_sdce0));
            check_errors++;
        end

    // Zero outside valid beats
    assert property (@(posedge clk) disable iff (rst)
                     epd_sd == (exp2_valid ? exp2_sd : 8'h00))
        else begin
            $display("Fail epd_sd expected 0x%h got 0x%h",
                     $sampled(exp2_valid ? exp2_sd : 8'h00), $sampled(epd_sd));
            check_errors++;
        end

    assert property (@(posedge clk) disable iff (rst) !exp2_valid || bo_pixel == exp2_bo)
        else begin
            $display("Fail bo_pixel expected 0x%h got 0x%h", $sampled(exp2_bo),
                     $sampled(bo_pixel));
            check_errors++;
        end

    assert property (@(posedge clk) disable iff (rst) bi_ready == vin_ready)
        else begin
            $display("Fail bi_ready expected 0x%h got 0x%h", $sampled(vin_ready),
                     $sampled(bi_ready));
            check_errors++;
        end

    assert property (@(posedge clk) disable iff (rst) !quiet || ctrl_bus == CTRL_IDLE)
        else begin
            $display("Fail control_outputs expected 0x%h got 0x%h", CTRL_IDLE,
                     $sampled(ctrl_bus));
            check_errors++;
        end

    ////////////////////////////////////////
    // Stimulus

    // New random beat on every falling edge, mostly fast mono words
    always @(negedge clk) begin : data_gen
        logic [31:0] r;
        logic [15:0] w;
        r = $random(seed);
        vin_pixel = r[15:0];
        for (int i = 0; i < 4; i++) begin
            r = $random(seed);
            w = r[15:0];
            if (r[18:16] != 3'd0) w[15:14] = 2'b01;
            if (r[19]) w[9:4] = 6'd0;
            bi_pixel[16*i +: 16] = w;
        end
    end

    task automatic check_count(string name, int got, int expected);
        assert (got == expected)
            else begin
                $display("Fail %s expected 0x%h got 0x%h", name, expected, got);
                count_errors++;
            end
    endtask

    // Starts on a falling edge with the controller idle
    task automatic run_frame();
        int wait_cycles;
        int trig_cycles;
        int ready_cnt;
        int valid_cnt;
        int le_cnt;
        int sp_cnt;
        int trig_scan;
        wait_cycles = 0;
        trig_cycles = 0;
        ready_cnt   = 0;
        valid_cnt   = 0;
        le_cnt      = 0;
        sp_cnt      = 0;
        trig_scan   = 0;
        vin_vsync = 1'b1;
        @(negedge clk);
        vin_vsync = 1'b0;
        while (!b_trigger && wait_cycles < ACCEPT_TIMEOUT) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (!b_trigger) begin
            $display("Timeout: frame sync not accepted before frame %0d", frames_done);
            timeout_errors++;
            timed_out = 1'b1;
            return;
        end
        while (b_trigger && trig_cycles < TRIGGER_TIMEOUT) begin
            trig_cycles++;
            @(negedge clk);
        end
        if (b_trigger) begin
            $display("Timeout: b_trigger stuck high in frame %0d", frames_done);
            timeout_errors++;
            timed_out = 1'b1;
            return;
        end
        check_count("b_trigger_cycles", trig_cycles, caster_pkg::VS_DELAY + 1);
        // Frame sync held high over the whole scan, an early return to idle restarts
        vin_vsync = 1'b1;
        for (int c = 0; c < caster_pkg::H_TOTAL * caster_pkg::V_TOTAL; c++) begin
            ready_cnt += vin_ready;
            valid_cnt += bo_valid;
            le_cnt    += epd_sdle;
            sp_cnt    += !epd_gdsp;
            trig_scan += b_trigger;
            @(negedge clk);
        end
        vin_vsync = 1'b0;
        check_count("vin_ready_cycles", ready_cnt, 64);
        check_count("bo_valid_cycles", valid_cnt, 64);
        check_count("epd_sdle_pulses", le_cnt, 14);
        check_count("epd_gdsp_low_cycles", sp_cnt, 12);
        check_count("b_trigger_in_scan", trig_scan, 0);
        frames_done++;
    endtask

    initial begin
        rst            = 1'b1;
        sys_ready      = 1'b0;
        vin_vsync      = 1'b0;
        vin_valid      = 1'b1;
        bi_valid       = 1'b1;
        quiet          = 1'b1;
        timed_out      = 1'b0;
        frames_done    = 0;
        check_errors   = 0;
        count_errors   = 0;
        timeout_errors = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Frame syncs without sys_ready are ignored
        for (int i = 0; i < 24; i++) begin
            @(negedge clk);
            vin_vsync = i[1];
        end
        @(negedge clk);
        vin_vsync = 1'b0;
        @(negedge clk);
        quiet     = 1'b0;
        sys_ready = 1'b1;

        for (int f = 0; f < caster_pkg::INIT_FRAMES + NORMAL_FRAMES && !timed_out; f++) begin
            run_frame();
        end

        $display("Errors: checks %0d, frame counts %0d, timeouts %0d",
                 check_errors, count_errors, timeout_errors);
        if (check_errors + count_errors + timeout_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
logic/caster_pkg.sv
logic/scan_if.sv
logic/scan_timing.sv
logic/op_sequencer.sv
logic/pixel_update.sv
logic/pixel_datapath.sv
logic/epd_drive.sv
logic/caster_top.sv
bench/caster_tb.sv

//--- Bender.yml
package:
  name: caster

sources:
  - logic/caster_pkg.sv
  - logic/scan_if.sv
  - logic/scan_timing.sv
  - logic/op_sequencer.sv
  - logic/pixel_update.sv
  - logic/pixel_datapath.sv
  - logic/epd_drive.sv
  - logic/caster_top.sv
  - target: simulation
    files:
      - bench/caster_tb.sv
